//--- prefixArith.f
+incdir+.
prefixArith_pkg.sv
wbBus_if.sv
PrefixAndOr.sv
prefixAdder.sv
arithEngine.sv
wbArbiter.sv
prefixArith.sv
prefixArith_properties.sv
prefixArith_tb.sv

//--- Bender.yml
package:
  name: prefixArith

sources:
  - include_dirs:
      - .
    files:
      - prefixArith_pkg.sv
      - wbBus_if.sv
      - PrefixAndOr.sv
      - prefixAdder.sv
      - arithEngine.sv
      - wbArbiter.sv
      - prefixArith.sv
  - target: test
    include_dirs:
      - .
    files:
      - prefixArith_properties.sv
      - prefixArith_tb.sv

//--- prefixArith_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefixArith_macros.svh"

// random add/sub jobs on both engines against a wishbone memory model
module prefixArith_tb import prefixArith_pkg::*; ();

	localparam logic [31:0] SEED        = 32'h12b145f0;
	localparam logic [31:0] TAPS        = 32'h80200003;  // x^32+x^22+x^2+x+1
	localparam int          JOB_TIMEOUT = 200;           // cycles per job

	logic               clk;
	logic               rstN;
	logic               start0;
	arithOp_e           op0;
	logic [`ADDR_W-1:0] adrA0;
	logic [`ADDR_W-1:0] adrB0;
	logic [`ADDR_W-1:0] adrD0;
	logic               busy0;
	logic               done0;
	logic               carry0;
	logic               start1;
	arithOp_e           op1;
	logic [`ADDR_W-1:0] adrA1;
	logic [`ADDR_W-1:0] adrB1;
	logic [`ADDR_W-1:0] adrD1;
	logic               busy1;
	logic               done1;
	logic               carry1;
	logic               wbCyc;
	logic               wbStb;
	logic               wbWe;
	logic [`ADDR_W-1:0] wbAdr;
	logic [`DATA_W-1:0] wbDatW;
	logic [`DATA_W-1:0] wbDatR;
	logic               wbAck;

	logic [`DATA_W-1:0] mem [256];  // shared memory
	int                 writeCnt [256];
	int                 totalWrites = 0;
	int                 jobs = 0;
	int                 checks = 0;
	int                 errors = 0;
	int                 timeouts = 0;
	logic [31:0]        stimLfsr = SEED;  // operands, addresses, junk starts
	logic [31:0]        waitLfsr = SEED;  // memory wait states
	logic               inXfer = 1'b0;
	int                 waitLeft = 0;

	prefixArith u_dut (
		.clk(clk), .rstN(rstN),
		.start0(start0), .op0(op0), .adrA0(adrA0), .adrB0(adrB0), .adrD0(adrD0),
		.busy0(busy0), .done0(done0), .carry0(carry0),
		.start1(start1), .op1(op1), .adrA1(adrA1), .adrB1(adrB1), .adrD1(adrD1),
		.busy1(busy1), .done1(done1), .carry1(carry1),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [15:0] takeBits(input int n, input logic forWait);
		logic [31:0] s;
		logic [15:0] v;
		s = forWait ? waitLfsr : stimLfsr;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], s[0]};
			s = (s >> 1) ^ (s[0] ? TAPS : 32'h0);
		end
		if (forWait) waitLfsr = s;
		else stimLfsr = s;
		return v;
	endfunction

	// reference: {carry, result}, carry on sub means a >= b
	function automatic logic [`DATA_W:0] predict(input arithOp_e op,
			input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b);
		if (op == ARITH_ADD) return {1'b0, a} + {1'b0, b};
		return {a >= b, a - b};
	endfunction

	task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("[FAIL] %s exp=%h got=%h", name, exp, got);
		end
	endtask

	task automatic checkJob(input int e, input arithCmd_t c, input logic [`DATA_W:0] exp,
			input int cntBefore);
		checkEq($sformatf("mem[adrD%0d]", e), exp[`DATA_W-1:0], mem[c.adrD]);
		checkEq($sformatf("carry%0d", e), exp[`DATA_W], (e == 0) ? carry0 : carry1);
		checkEq($sformatf("writes to adrD%0d", e), 1, writeCnt[c.adrD] - cntBefore);
	endtask

	// memory model, ack after 0..3 wait cycles
	always @(negedge clk) begin
		wbAck = 1'b0;  // ack lasts one cycle
		if (!rstN) begin
			inXfer = 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!inXfer) begin  // new transfer
				inXfer   = 1'b1;
				waitLeft = takeBits(2, 1'b1);
			end
			if (waitLeft == 0) begin
				inXfer = 1'b0;
				wbAck  = 1'b1;
				if (wbWe) begin
					mem[wbAdr] = wbDatW;
					writeCnt[wbAdr]++;
					totalWrites++;
				end else begin
					wbDatR = mem[wbAdr];
				end
			end else begin
				waitLeft--;
			end
		end
	end

	// opMode 0 add, 1 sub, 2 random; engine 1 stays in the upper half
	task automatic runJob(input logic use0, input logic use1, input int opMode,
			input logic sameOps, input logic junk);
		arithCmd_t         c [2];
		logic [`DATA_W:0]  exp [2];
		int                cntBefore [2];
		logic              seen [2];
		int                n;
		for (int e = 0; e < 2; e++) begin
			c[e].op   = (opMode == 2) ? arithOp_e'(takeBits(1, 1'b0)) : arithOp_e'(opMode);
			c[e].adrA = {1'(e), 7'(takeBits(7, 1'b0))};
			c[e].adrB = {1'(e), 7'(takeBits(7, 1'b0))};
			c[e].adrD = {1'(e), 7'(takeBits(7, 1'b0))};
		end
		if (sameOps) begin  // mirror engine 0's job into the upper half
			c[1] = '{op: c[0].op, adrA: c[0].adrA | 8'h80, adrB: c[0].adrB | 8'h80,
				adrD: c[0].adrD | 8'h80};
			mem[c[1].adrA] = mem[c[0].adrA];
			mem[c[1].adrB] = mem[c[0].adrB];
		end
		for (int e = 0; e < 2; e++) begin
			exp[e]       = predict(c[e].op, mem[c[e].adrA], mem[c[e].adrB]);
			cntBefore[e] = writeCnt[c[e].adrD];
		end
		seen[0] = !use0;
		seen[1] = !use1;
		jobs += int'(use0) + int'(use1);
		@(negedge clk);
		start0 = use0;
		op0    = c[0].op;
		adrA0  = c[0].adrA;
		adrB0  = c[0].adrB;
		adrD0  = c[0].adrD;
		start1 = use1;
		op1    = c[1].op;
		adrA1  = c[1].adrA;
		adrB1  = c[1].adrB;
		adrD1  = c[1].adrD;
		for (n = 0; n < JOB_TIMEOUT && !(seen[0] && seen[1]); n++) begin
			@(negedge clk);
			if (n == 0) begin  // busy one cycle after start
				if (use0) checkEq("busy0", 1, busy0);
				if (use1) checkEq("busy1", 1, busy1);
			end
			start0 = 1'b0;
			start1 = 1'b0;
			if (done0 && !seen[0]) begin
				seen[0] = 1'b1;
				checkJob(0, c[0], exp[0], cntBefore[0]);
			end
			if (done1 && !seen[1]) begin
				seen[1] = 1'b1;
				checkJob(1, c[1], exp[1], cntBefore[1]);
			end
			if (junk && busy0 && takeBits(2, 1'b0) == 0) begin  // must be ignored
				start0 = 1'b1;
				op0    = arithOp_e'(takeBits(1, 1'b0));
				adrA0  = 8'(takeBits(8, 1'b0));
				adrD0  = 8'(takeBits(8, 1'b0));
			end
			if (junk && busy1 && takeBits(2, 1'b0) == 0) begin
				start1 = 1'b1;
				op1    = arithOp_e'(takeBits(1, 1'b0));
				adrB1  = 8'(takeBits(8, 1'b0));
				adrD1  = 8'(takeBits(8, 1'b0));
			end
		end
		start0 = 1'b0;
		start1 = 1'b0;
		if (!seen[0]) begin
			timeouts++;
			$display("timeout: engine 0 never raised done0 for its job");
		end
		if (!seen[1]) begin
			timeouts++;
			$display("timeout: engine 1 never raised done1 for its job");
		end
		if (sameOps && seen[0] && seen[1]) begin  // sklansky vs serial
			checkEq("result eng1 vs eng0", mem[c[0].adrD], mem[c[1].adrD]);
			checkEq("carry1 vs carry0", carry0, carry1);
		end
	endtask

	initial begin
		rstN   = 1'b0;
		start0 = 1'b0;
		op0    = ARITH_ADD;
		adrA0  = '0;
		adrB0  = '0;
		adrD0  = '0;
		start1 = 1'b0;
		op1    = ARITH_ADD;
		adrA1  = '0;
		adrB1  = '0;
		adrD1  = '0;
		wbDatR = '0;
		wbAck  = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i]      = takeBits(16, 1'b0);
			writeCnt[i] = 0;
		end
		repeat (10) @(negedge clk);
		rstN = 1'b1;

		repeat (3) begin  // idle after reset
			@(negedge clk);
			checkEq("busy0", 0, busy0);
			checkEq("busy1", 0, busy1);
			checkEq("done0", 0, done0);
			checkEq("done1", 0, done1);
			checkEq("wbCyc", 0, wbCyc);
			checkEq("wbStb", 0, wbStb);
		end

		for (int i = 0; i < 20; i++) begin  // each engine alone
			runJob(1'b1, 1'b0, 0, 1'b0, 1'b0);
			runJob(1'b0, 1'b1, 0, 1'b0, 1'b0);
			runJob(1'b1, 1'b0, 1, 1'b0, 1'b0);
			runJob(1'b0, 1'b1, 1, 1'b0, 1'b0);
		end
		for (int i = 0; i < 40; i++) runJob(1'b1, 1'b1, 2, 1'b0, 1'b0);  // contention
		for (int i = 0; i < 20; i++) runJob(1'b1, 1'b1, 2, 1'b1, 1'b0);
		for (int i = 0; i < 30; i++) begin  // starts while busy
			runJob(1'b1, 1'b1, 2, 1'b0, 1'b1);
			runJob(1'b1, 1'b0, 2, 1'b0, 1'b1);
		end
		checkEq("total writes", jobs, totalWrites);

		$display("checks=%0d mismatches=%0d timeouts=%0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- prefixArith_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefixArith_macros.svh"

// protocol checks on the shared wishbone port and engine status
module prefixArith_properties (
	input logic               clk,
	input logic               rstN,
	input logic               wbCyc,
	input logic               wbStb,
	input logic               wbWe,
	input logic               wbAck,
	input logic [`ADDR_W-1:0] wbAdr,
	input logic [`DATA_W-1:0] wbDatW,
	input logic               busy0,
	input logic               done0,
	input logic               busy1,
	input logic               done1
);

	aStbInCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
		else $error("wbStb high outside a bus cycle");

	// request held steady until acked
	aHeld: assert property (@(posedge clk) disable iff (!rstN)
		(wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW)))
		else $error("wishbone request changed before ack");

	// done comes right after the last busy cycle and busy is already low
	aDone0: assert property (@(posedge clk) disable iff (!rstN)
		done0 |-> (!busy0 && $past(busy0)))
		else $error("done0 not right after a busy cycle");
	aDone1: assert property (@(posedge clk) disable iff (!rstN)
		done1 |-> (!busy1 && $past(busy1)))
		else $error("done1 not right after a busy cycle");

endmodule

bind prefixArith prefixArith_properties u_props (.*);

`default_nettype wire

//--- prefixArith.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefixArith_macros.svh"

// two add/sub engines sharing one wishbone port
module prefixArith import prefixArith_pkg::*; (
	input  logic               clk,
	input  logic               rstN,
	// engine 0, sklansky adder
	input  logic               start0,
	input  arithOp_e           op0,
	input  logic [`ADDR_W-1:0] adrA0,
	input  logic [`ADDR_W-1:0] adrB0,
	input  logic [`ADDR_W-1:0] adrD0,
	output logic               busy0,
	output logic               done0,
	output logic               carry0,
	// engine 1, serial adder
	input  logic               start1,
	input  arithOp_e           op1,
	input  logic [`ADDR_W-1:0] adrA1,
	input  logic [`ADDR_W-1:0] adrB1,
	input  logic [`ADDR_W-1:0] adrD1,
	output logic               busy1,
	output logic               done1,
	output logic               carry1,
	// shared memory port
	output logic               wbCyc,
	output logic               wbStb,
	output logic               wbWe,
	output logic [`ADDR_W-1:0] wbAdr,
	output logic [`DATA_W-1:0] wbDatW,
	input  logic [`DATA_W-1:0] wbDatR,
	input  logic               wbAck
);

	arithCmd_t cmd0;
	arithCmd_t cmd1;

	wbBus_if bus0 ();
	wbBus_if bus1 ();
	wbBus_if busExt ();  // arbiter output

	assign cmd0 = '{op: op0, adrA: adrA0, adrB: adrB0, adrD: adrD0};
	assign cmd1 = '{op: op1, adrA: adrA1, adrB: adrB1, adrD: adrD1};

	arithEngine #(
		.speed(2)
	) u_eng0 (
		.clk(clk),
		.rstN(rstN),
		.start(start0),
		.cmd(cmd0),
		.busy(busy0),
		.done(done0),
		.carry(carry0),
		.wb(bus0.master)
	);

	arithEngine #(
		.speed(0)
	) u_eng1 (
		.clk(clk),
		.rstN(rstN),
		.start(start1),
		.cmd(cmd1),
		.busy(busy1),
		.done(done1),
		.carry(carry1),
		.wb(bus1.master)
	);

	wbArbiter u_arb (
		.clk(clk),
		.rstN(rstN),
		.m0(bus0.slave),
		.m1(bus1.slave),
		.s(busExt.master)
	);

	assign wbCyc       = busExt.cyc;
	assign wbStb       = busExt.stb;
	assign wbWe        = busExt.we;
	assign wbAdr       = busExt.adr;
	assign wbDatW      = busExt.datW;
	assign busExt.datR = wbDatR;
	assign busExt.ack  = wbAck;

endmodule

`default_nettype wire

//--- wbArbiter.sv
`timescale 1ns/1ps
`default_nettype none

// round-robin arbiter, two wishbone masters onto one bus
// owner keeps the bus as long as its cyc stays high
module wbArbiter (
	input  logic   clk,
	input  logic   rstN,
	wbBus_if.slave  m0,
	wbBus_if.slave  m1,
	wbBus_if.master s
);

	logic owned;     // registered grant valid
	logic ownIdx;    // registered grant owner
	logic lastIdx;   // master served last
	logic sel;       // effective grant this cycle
	logic selValid;

	// hold the owner, else pick without losing a cycle
	always_comb begin
		if (owned && (ownIdx ? m1.cyc : m0.cyc)) begin
			sel      = ownIdx;
			selValid = 1'b1;
		end else if (m0.cyc && m1.cyc) begin
			sel      = ~lastIdx;  // the one not served last
			selValid = 1'b1;
		end else begin
			sel      = m1.cyc;
			selValid = m0.cyc | m1.cyc;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			owned   <= 1'b0;
			ownIdx  <= 1'b0;
			lastIdx <= 1'b1;  // m0 first on a tie
		end else begin
			owned  <= selValid;
			ownIdx <= sel;
			if (selValid) lastIdx <= sel;
		end
	end

	// request mux
	assign s.cyc  = selValid;
	assign s.stb  = selValid & (sel ? m1.stb : m0.stb);
	assign s.we   = sel ? m1.we : m0.we;
	assign s.adr  = sel ? m1.adr : m0.adr;
	assign s.datW = sel ? m1.datW : m0.datW;

	// responses to the granted master only
	assign m0.ack  = s.ack & selValid & ~sel;
	assign m1.ack  = s.ack & selValid & sel;
	assign m0.datR = sel ? '0 : s.datR;
	assign m1.datR = sel ? s.datR : '0;

endmodule

`default_nettype wire

//--- arithEngine.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefixArith_macros.svh"

// memory-to-memory add/sub engine, wishbone master
// job: read a, read b, write d, all under one cyc
module arithEngine import prefixArith_pkg::*; #(
	parameter int speed = 2  // prefix structure of the adder
) (
	input  logic      clk,
	input  logic      rstN,
	input  logic      start,  // one-cycle pulse, ignored while busy
	input  arithCmd_t cmd,
	output logic      busy,
	output logic      done,   // one cycle after the write ack
	output logic      carry,  // cout of the last job, 1 = no borrow on sub
	wbBus_if.master   wb
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RDA,
		S_RDB,
		S_WR,
		S_FIN
	} state_e;

	state_e             state;
	arithCmd_t          cmdQ;      // latched job
	logic [`DATA_W-1:0] opA;
	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] addB;      // b or ~b
	logic [`DATA_W-1:0] sum;
	logic               cout;
	logic               isSub;
	logic               cycQ;
	logic               stbQ;
	logic               xferDone;  // current transfer acked
	logic               accept;

	assign isSub    = (cmdQ.op == ARITH_SUB);
	assign addB     = isSub ? ~opB : opB;  // a - b = a + ~b + 1
	assign xferDone = stbQ & wb.ack;
	assign accept   = start & ~busy;

	prefixAdder #(
		.speed(speed)
	) u_adder (
		.a(opA),
		.b(addB),
		.cin(isSub),
		.sum(sum),
		.cout(cout)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= S_IDLE;
			cycQ  <= 1'b0;
			stbQ  <= 1'b0;
			carry <= 1'b0;
		end else begin
			case (state)
				S_IDLE, S_FIN: begin
					if (accept) begin  // cyc and stb up together
						state <= S_RDA;
						cycQ  <= 1'b1;
						stbQ  <= 1'b1;
					end else begin
						state <= S_IDLE;
					end
				end
				S_RDA: begin
					if (xferDone) begin
						state <= S_RDB;
						stbQ  <= 1'b0;  // one idle cycle between transfers
					end
				end
				S_RDB: begin
					if (xferDone) begin
						state <= S_WR;
						stbQ  <= 1'b0;
					end else begin
						stbQ <= 1'b1;  // raise after the gap, hold until ack
					end
				end
				S_WR: begin
					if (xferDone) begin
						state <= S_FIN;
						stbQ  <= 1'b0;
						cycQ  <= 1'b0;  // release the bus
						carry <= cout;
					end else begin
						stbQ <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// job and operand capture
	always_ff @(posedge clk) begin
		if (accept) cmdQ <= cmd;
		if (xferDone && state == S_RDA) opA <= wb.datR;
		if (xferDone && state == S_RDB) opB <= wb.datR;
	end

	always_comb begin
		case (state)
			S_RDA:   wb.adr = cmdQ.adrA;
			S_RDB:   wb.adr = cmdQ.adrB;
			default: wb.adr = cmdQ.adrD;
		endcase
	end

	assign wb.cyc  = cycQ;
	assign wb.stb  = stbQ;
	assign wb.we   = (state == S_WR);
	assign wb.datW = sum;  // operands steady during the write

	assign busy = (state == S_RDA) || (state == S_RDB) || (state == S_WR);
	assign done = (state == S_FIN);

endmodule

`default_nettype wire

//--- prefixAdder.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefixArith_macros.svh"

// parallel-prefix adder around PrefixAndOr, purely combinational
module prefixAdder #(
	parameter int speed = 2  // handed to the prefix network
) (
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	input  logic               cin,
	output logic [`DATA_W-1:0] sum,
	output logic               cout
);

	logic [`DATA_W-1:0] gBit;   // bit generate
	logic [`DATA_W-1:0] pBit;   // bit propagate, also the half sum
	logic [`DATA_W-1:0] gIn;    // generate with cin folded into bit 0
	logic [`DATA_W-1:0] carry;  // carry out of each bit position

	assign gBit = a & b;
	assign pBit = a ^ b;
	assign gIn  = {gBit[`DATA_W-1:1], gBit[0] | (pBit[0] & cin)};

	PrefixAndOr #(
		.width(`DATA_W),
		.speed(speed)
	) u_prefix (
		.GI(gIn),
		.PI(pBit),
		.GO(carry),
		.PO()  // group propagate not needed, cin already folded in
	);

	assign sum  = pBit ^ {carry[`DATA_W-2:0], cin};  // carry into each bit
	assign cout = carry[`DATA_W-1];

endmodule

`default_nettype wire

//--- PrefixAndOr.sv
`timescale 1ns/1ps
`default_nettype none

// generate/propagate prefix network for carry computation
// GO[i] is the group generate of bits i..0, PO[i] the group propagate
// speed 2 sklansky, 1 brent-kung, 0 serial chain
module PrefixAndOr #(
	parameter int width = 8,  // number of bit positions
	parameter int speed = 2   // depth versus cell count
) (
	input  logic [width-1:0] GI,  // bit generate
	input  logic [width-1:0] PI,  // bit propagate
	output logic [width-1:0] GO,  // group generate, i.e. carries
	output logic [width-1:0] PO   // group propagate
);

	localparam int dep = $clog2(width);  // levels of the log-depth trees

	if (speed == 2) begin : gSklansky
		logic [dep:0][width-1:0] gL;  // generate per level
		logic [dep:0][width-1:0] pL;  // propagate per level

		assign gL[0] = GI;
		assign pL[0] = PI;

		for (genvar l = 1; l <= dep; l++) begin : gLvl
			for (genvar i = 0; i < width; i++) begin : gCol
				// last bit of the lower half of this 2^l block
				localparam int src = ((i >> l) << l) + 2 ** (l - 1) - 1;
				if (((i >> (l - 1)) % 2) == 1) begin : gBlack
					assign gL[l][i] = gL[l-1][i] | (pL[l-1][i] & gL[l-1][src]);
					assign pL[l][i] = pL[l-1][i] & pL[l-1][src];
				end else begin : gWhite
					assign gL[l][i] = gL[l-1][i];  // lower half just passes
					assign pL[l][i] = pL[l-1][i];
				end
			end
		end

		assign GO = gL[dep];
		assign PO = pL[dep];
	end else if (speed == 1) begin : gBrentKung
		logic [2*dep-1:0][width-1:0] gL;  // up sweep, then down sweep
		logic [2*dep-1:0][width-1:0] pL;

		assign gL[0] = GI;
		assign pL[0] = PI;

		// up sweep, block tops collect their whole block
		for (genvar l = 1; l <= dep; l++) begin : gUp
			for (genvar i = 0; i < width; i++) begin : gCol
				if (((i + 1) % (2 ** l)) == 0) begin : gBlack
					assign gL[l][i] = gL[l-1][i] | (pL[l-1][i] & gL[l-1][i-2**(l-1)]);
					assign pL[l][i] = pL[l-1][i] & pL[l-1][i-2**(l-1)];
				end else begin : gWhite
					assign gL[l][i] = gL[l-1][i];
					assign pL[l][i] = pL[l-1][i];
				end
			end
		end

		// down sweep fills the mid points from left neighbours
		for (genvar l = dep + 1; l < 2 * dep; l++) begin : gDown
			for (genvar i = 0; i < width; i++) begin : gCol
				localparam int s = 2 * dep - l;  // span shrinks per level
				if ((((i + 1) % (2 ** s)) == 2 ** (s - 1)) && (i >= 2 ** s)) begin : gBlack
					assign gL[l][i] = gL[l-1][i] | (pL[l-1][i] & gL[l-1][i-2**(s-1)]);
					assign pL[l][i] = pL[l-1][i] & pL[l-1][i-2**(s-1)];
				end else begin : gWhite
					assign gL[l][i] = gL[l-1][i];
					assign pL[l][i] = pL[l-1][i];
				end
			end
		end

		assign GO = gL[2*dep-1];
		assign PO = pL[2*dep-1];
	end else begin : gSerial
		logic [width-1:0] gC;  // ripple chain
		logic [width-1:0] pC;

		assign gC[0] = GI[0];
		assign pC[0] = PI[0];

		for (genvar i = 1; i < width; i++) begin : gCol
			assign gC[i] = GI[i] | (PI[i] & gC[i-1]);
			assign pC[i] = PI[i] & pC[i-1];
		end

		assign GO = gC;
		assign PO = pC;
	end

endmodule

`default_nettype wire

//--- wbBus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefixArith_macros.svh"

// wishbone classic, single transfers only
interface wbBus_if;
	logic               cyc;   // bus cycle, held for a whole job
	logic               stb;   // transfer strobe
	logic               we;    // write enable
	logic [`ADDR_W-1:0] adr;   // word address
	logic [`DATA_W-1:0] datW;  // write data
	logic [`DATA_W-1:0] datR;  // read data, valid with ack
	logic               ack;   // one-cycle transfer ack

	modport master (
		output cyc, stb, we, adr, datW,
		input  datR, ack
	);

	modport slave (
		input  cyc, stb, we, adr, datW,
		output datR, ack
	);
endinterface

`default_nettype wire

//--- prefixArith_pkg.sv
`default_nettype none

`include "prefixArith_macros.svh"

package prefixArith_pkg;

	// operation of one job
	typedef enum logic {
		ARITH_ADD = 1'b0,
		ARITH_SUB = 1'b1  // a minus b
	} arithOp_e;

	// one job: d = a op b, all word addresses
	typedef struct packed {
		arithOp_e          op;
		logic [`ADDR_W-1:0] adrA;  // first operand
		logic [`ADDR_W-1:0] adrB;  // second operand
		logic [`ADDR_W-1:0] adrD;  // destination
	} arithCmd_t;

endpackage

`default_nettype wire

//--- prefixArith_macros.svh
`ifndef PREFIXARITH_MACROS_SVH
`define PREFIXARITH_MACROS_SVH

// operand and result width, one memory word
`define DATA_W 16

// word address width of the shared memory
`define ADDR_W 8

`endif
